// ==== src/pong_link_pkg.sv ====
package pong_link_pkg;

    // 7-bit target address 0x55 plus the write bit
    localparam logic [7:0] link_addr = 8'haa;

    // tag byte sent right after the address
    typedef enum logic [7:0] {
        frame_ball  = 8'h01,
        frame_score = 8'h02
    } frame_kind_t;

    // data bytes after the tag
    localparam int ball_payload_len  = 6;
    localparam int score_payload_len = 1;

    // which sender holds the byte master
    typedef enum logic [1:0] {
        owner_none,
        owner_ball,
        owner_score
    } owner_t;

endpackage

// ==== src/i2c_byte_master.sv ====
module i2c_byte_master #(
    parameter int clk_div = 4
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  logic       stop,
    input  logic       i2c_en,
    input  logic [7:0] tx_data,
    input  logic       sda_in,
    output logic       ready,
    output logic       tx_done,
    output logic       nack,
    output logic       scl,
    output logic       sda_low
);

    localparam int cnt_w = $clog2(clk_div);

    typedef enum logic [2:0] {
        idle,
        start_cond,
        data_bit,
        ack_bit,
        stop_cond
    } state_t;

    state_t state;
    logic [cnt_w-1:0] q_cnt;
    logic [1:0] phase;      // quarter within the current bit
    logic [2:0] bit_cnt;
    logic [7:0] shift;
    logic ack_seen;
    logic tick;

    assign tick = (q_cnt == cnt_w'(clk_div - 1));  // last clk of a quarter

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= idle;
            q_cnt    <= '0;
            phase    <= '0;
            bit_cnt  <= '0;
            ack_seen <= 1'b0;
            ready    <= 1'b1;
            tx_done  <= 1'b0;
            nack     <= 1'b0;
            scl      <= 1'b1;
            sda_low  <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            nack    <= 1'b0;
            if (state == idle) begin
                q_cnt <= '0;
                phase <= '0;
                if (i2c_en) begin
                    ready <= 1'b0;
                    if (start) begin
                        state   <= start_cond;
                        sda_low <= 1'b1;     // sda falls while scl high
                    end else if (stop) begin
                        state   <= stop_cond;
                        scl     <= 1'b0;
                        sda_low <= 1'b1;
                    end else begin
                        state   <= data_bit;
                        bit_cnt <= '0;
                        scl     <= 1'b0;
                        sda_low <= ~tx_data[7];  // msb first
                    end
                end
            end else begin
                q_cnt <= tick ? '0 : q_cnt + 1'b1;
                if (tick) begin
                    phase <= phase + 2'd1;
                    case (state)
                        start_cond: begin
                            if (phase == 2'd0) begin
                                scl <= 1'b0;
                            end else begin
                                state <= idle;
                                ready <= 1'b1;
                            end
                        end
                        data_bit: begin
                            case (phase)
                                2'd0: scl <= 1'b1;
                                2'd2: scl <= 1'b0;
                                2'd3: begin
                                    if (bit_cnt == 3'd7) begin
                                        state   <= ack_bit;
                                        sda_low <= 1'b0;  // let the target drive ack
                                    end else begin
                                        bit_cnt <= bit_cnt + 3'd1;
                                        sda_low <= ~shift[6];
                                    end
                                end
                                default: ;
                            endcase
                        end
                        ack_bit: begin
                            case (phase)
                                2'd0: scl <= 1'b1;
                                2'd1: ack_seen <= sda_in;  // scl high midpoint
                                2'd2: scl <= 1'b0;
                                2'd3: begin
                                    state   <= idle;
                                    ready   <= 1'b1;
                                    tx_done <= 1'b1;
                                    nack    <= ack_seen;
                                end
                            endcase
                        end
                        stop_cond: begin
                            case (phase)
                                2'd0: scl <= 1'b1;
                                2'd1: sda_low <= 1'b0;   // sda rises while scl high
                                default: begin
                                    state <= idle;
                                    ready <= 1'b1;
                                end
                            endcase
                        end
                        default: state <= idle;
                    endcase
                end
            end
        end
    end

    // byte shifter, loaded on a data command
    always_ff @(posedge clk) begin
        if (state == idle && i2c_en && !start && !stop) begin
            shift <= tx_data;
        end else if (state == data_bit && tick && phase == 2'd3) begin
            shift <= {shift[6:0], 1'b0};
        end
    end

endmodule

// ==== src/i2c_bus_arbiter.sv ====
module i2c_bus_arbiter (
    input  logic       clk,
    input  logic       reset,
    input  logic       ball_start,
    input  logic       ball_stop,
    input  logic       ball_en,
    input  logic [7:0] ball_data,
    output logic       ball_ready,
    input  logic       score_start,
    input  logic       score_stop,
    input  logic       score_en,
    input  logic [7:0] score_data,
    output logic       score_ready,
    output logic       m_start,
    output logic       m_stop,
    output logic       m_en,
    output logic [7:0] m_data,
    input  logic       m_ready
);

    pong_link_pkg::owner_t owner;
    logic stop_pending;     // stop accepted, waiting for ready

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            owner        <= pong_link_pkg::owner_none;
            stop_pending <= 1'b0;
        end else if (owner == pong_link_pkg::owner_none) begin
            if (m_ready) begin
                if (ball_start && ball_en) begin  // ball wins a tie
                    owner <= pong_link_pkg::owner_ball;
                end else if (score_start && score_en) begin
                    owner <= pong_link_pkg::owner_score;
                end
            end
        end else if (stop_pending && m_ready) begin
            owner        <= pong_link_pkg::owner_none;
            stop_pending <= 1'b0;
        end else if (m_stop && m_en && m_ready) begin
            stop_pending <= 1'b1;
        end
    end

    always_comb begin
        m_start = 1'b0;
        m_stop  = 1'b0;
        m_en    = 1'b0;
        m_data  = 8'h00;
        case (owner)
            pong_link_pkg::owner_ball: begin
                m_start = ball_start;
                m_stop  = ball_stop;
                m_en    = ball_en;
                m_data  = ball_data;
            end
            pong_link_pkg::owner_score: begin
                m_start = score_start;
                m_stop  = score_stop;
                m_en    = score_en;
                m_data  = score_data;
            end
            default: ;
        endcase
    end

    // non-owner keeps seeing ready and waits in its start state
    assign ball_ready  = (owner == pong_link_pkg::owner_ball) ? m_ready : 1'b1;
    assign score_ready = (owner == pong_link_pkg::owner_score) ? m_ready : 1'b1;

endmodule

// ==== src/ball_frame_sender.sv ====
module ball_frame_sender (
    input  logic       clk,
    input  logic       reset,
    input  logic       send_trigger,
    input  logic [9:0] ball_y,
    input  logic [7:0] ball_vy,
    input  logic [1:0] gravity_step,
    input  logic       collision,
    input  logic       lose,
    input  logic       ready,
    output logic       start,
    output logic       stop,
    output logic       i2c_en,
    output logic [7:0] tx_data,
    output logic       frame_done
);

    localparam int last_idx = 1 + pong_link_pkg::ball_payload_len;
    localparam int pay_w = $clog2(pong_link_pkg::ball_payload_len);

    typedef enum logic [2:0] {
        idle,
        start_wait,
        wait_ready,
        send_byte,
        stop_wait,
        done_wait,
        hold_done
    } state_t;

    state_t state, state_next;
    logic [3:0] byte_idx, idx_next;  // 0 addr, 1 tag, then payload
    logic [pay_w-1:0] pay_idx;
    logic [7:0] payload [pong_link_pkg::ball_payload_len];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= idle;
            byte_idx <= '0;
        end else begin
            state    <= state_next;
            byte_idx <= idx_next;
        end
    end

    // ball state snapshot on the trigger
    always_ff @(posedge clk) begin
        if (state == idle && send_trigger) begin
            payload[0] <= {ball_y[9:8], 6'b0};
            payload[1] <= ball_y[7:0];
            payload[2] <= ball_vy;
            payload[3] <= {6'b0, gravity_step};
            payload[4] <= {7'b0, collision};
            payload[5] <= {7'b0, lose};
        end
    end

    assign pay_idx = pay_w'(byte_idx - 4'd2);

    always_comb begin
        case (byte_idx)
            4'd0: tx_data = pong_link_pkg::link_addr;
            4'd1: tx_data = pong_link_pkg::frame_ball;
            default: tx_data = (byte_idx <= 4'(last_idx)) ? payload[pay_idx] : 8'h00;
        endcase
    end

    always_comb begin
        state_next = state;
        idx_next   = byte_idx;
        start      = 1'b0;
        stop       = 1'b0;
        i2c_en     = 1'b0;
        frame_done = 1'b0;
        case (state)
            idle: begin
                idx_next = '0;
                if (send_trigger) begin
                    start      = 1'b1;
                    i2c_en     = 1'b1;
                    state_next = start_wait;
                end
            end
            start_wait: begin
                start  = 1'b1;
                i2c_en = 1'b1;
                if (!ready) state_next = wait_ready;  // held here until granted
            end
            wait_ready: begin
                if (ready) begin
                    state_next = (byte_idx > 4'(last_idx)) ? stop_wait : send_byte;
                end
            end
            send_byte: begin
                i2c_en = 1'b1;
                if (!ready) begin
                    idx_next   = byte_idx + 4'd1;
                    state_next = wait_ready;
                end
            end
            stop_wait: begin
                stop   = 1'b1;
                i2c_en = 1'b1;
                if (!ready) state_next = done_wait;
            end
            done_wait: begin
                if (ready) state_next = hold_done;
            end
            hold_done: begin
                frame_done = 1'b1;
                if (!send_trigger) state_next = idle;
            end
            default: state_next = idle;
        endcase
    end

endmodule

// ==== src/score_frame_sender.sv ====
module score_frame_sender (
    input  logic       clk,
    input  logic       reset,
    input  logic       score_update,
    input  logic [6:0] score,
    input  logic       lose,
    input  logic       ready,
    output logic       start,
    output logic       stop,
    output logic       i2c_en,
    output logic [7:0] tx_data,
    output logic       score_done
);

    localparam int last_idx = 1 + pong_link_pkg::score_payload_len;

    typedef enum logic [2:0] {
        idle,
        start_wait,
        wait_ready,
        send_byte,
        stop_wait,
        done_wait
    } state_t;

    state_t state, state_next;
    logic [1:0] byte_idx, idx_next;
    logic pending;
    logic [7:0] score_byte;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= idle;
            byte_idx <= '0;
            pending  <= 1'b0;
        end else begin
            state    <= state_next;
            byte_idx <= idx_next;
            if (state == idle && pending) begin
                pending <= 1'b0;              // frame starts now
            end else if (state == idle && score_update) begin
                pending <= 1'b1;
            end
        end
    end

    // updates during a frame are dropped
    always_ff @(posedge clk) begin
        if (state == idle && score_update) score_byte <= {lose, score};
    end

    always_comb begin
        case (byte_idx)
            2'd0: tx_data = pong_link_pkg::link_addr;
            2'd1: tx_data = pong_link_pkg::frame_score;
            default: tx_data = score_byte;
        endcase
    end

    always_comb begin
        state_next = state;
        idx_next   = byte_idx;
        start      = 1'b0;
        stop       = 1'b0;
        i2c_en     = 1'b0;
        score_done = 1'b0;
        case (state)
            idle: begin
                idx_next = '0;
                if (pending) begin
                    start      = 1'b1;
                    i2c_en     = 1'b1;
                    state_next = start_wait;
                end
            end
            start_wait: begin
                start  = 1'b1;
                i2c_en = 1'b1;
                if (!ready) state_next = wait_ready;
            end
            wait_ready: begin
                if (ready) begin
                    state_next = (byte_idx > 2'(last_idx)) ? stop_wait : send_byte;
                end
            end
            send_byte: begin
                i2c_en = 1'b1;
                if (!ready) begin
                    idx_next   = byte_idx + 2'd1;
                    state_next = wait_ready;
                end
            end
            stop_wait: begin
                stop   = 1'b1;
                i2c_en = 1'b1;
                if (!ready) state_next = done_wait;
            end
            done_wait: begin
                if (ready) begin
                    score_done = 1'b1;  // single cycle
                    state_next = idle;
                end
            end
            default: state_next = idle;
        endcase
    end

endmodule

// ==== src/pong_link_top.sv ====
module pong_link_top #(
    parameter int clk_div = 4
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       send_trigger,
    input  logic [9:0] ball_y,
    input  logic [7:0] ball_vy,
    input  logic [1:0] gravity_step,
    input  logic       collision,
    input  logic       lose,
    input  logic       score_update,
    input  logic [6:0] score,
    input  logic       sda_in,
    output logic       frame_done,
    output logic       score_done,
    output logic       nack,
    output logic       scl,
    output logic       sda_low
);

    logic       ball_start, ball_stop, ball_en, ball_ready;
    logic [7:0] ball_data;
    logic       score_start, score_stop, score_en, score_ready;
    logic [7:0] score_data;
    logic       m_start, m_stop, m_en, m_ready;
    logic [7:0] m_data;

    ball_frame_sender i_ball (
        .clk          (clk),
        .reset        (reset),
        .send_trigger (send_trigger),
        .ball_y       (ball_y),
        .ball_vy      (ball_vy),
        .gravity_step (gravity_step),
        .collision    (collision),
        .lose         (lose),
        .ready        (ball_ready),
        .start        (ball_start),
        .stop         (ball_stop),
        .i2c_en       (ball_en),
        .tx_data      (ball_data),
        .frame_done   (frame_done)
    );

    score_frame_sender i_score (
        .clk          (clk),
        .reset        (reset),
        .score_update (score_update),
        .score        (score),
        .lose         (lose),
        .ready        (score_ready),
        .start        (score_start),
        .stop         (score_stop),
        .i2c_en       (score_en),
        .tx_data      (score_data),
        .score_done   (score_done)
    );

    i2c_bus_arbiter i_arb (
        .clk         (clk),
        .reset       (reset),
        .ball_start  (ball_start),
        .ball_stop   (ball_stop),
        .ball_en     (ball_en),
        .ball_data   (ball_data),
        .ball_ready  (ball_ready),
        .score_start (score_start),
        .score_stop  (score_stop),
        .score_en    (score_en),
        .score_data  (score_data),
        .score_ready (score_ready),
        .m_start     (m_start),
        .m_stop      (m_stop),
        .m_en        (m_en),
        .m_data      (m_data),
        .m_ready     (m_ready)
    );

    i2c_byte_master #(
        .clk_div (clk_div)
    ) i_master (
        .clk     (clk),
        .reset   (reset),
        .start   (m_start),
        .stop    (m_stop),
        .i2c_en  (m_en),
        .tx_data (m_data),
        .sda_in  (sda_in),
        .ready   (m_ready),
        .tx_done (),         // senders pace on ready alone
        .nack    (nack),
        .scl     (scl),
        .sda_low (sda_low)
    );

endmodule

// ==== bench/i2c_target_model.sv ====
module i2c_target_model (
    input  logic scl,
    input  logic sda,
    input  logic nack_next,
    output logic sda_pull
);

    logic [7:0] rx_bytes [$];  // bytes of all recorded frames, in order
    int         rx_len [$];    // one entry per recorded frame
    int         stop_count = 0;
    logic [7:0] cur [$];
    logic [7:0] shift_in = 8'h00;
    int         bit_cnt = 0;
    logic       in_frame = 1'b0;
    logic       ignore = 1'b0;  // address was nacked

    initial sda_pull = 1'b0;

    // start: sda falls while scl high
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            in_frame = 1'b1;
            ignore   = 1'b0;
            bit_cnt  = 0;
            cur.delete();
        end
    end

    // stop: sda rises while scl high
    always @(posedge sda) begin
        if (scl === 1'b1 && in_frame) begin
            in_frame = 1'b0;
            stop_count++;
            if (!ignore) begin
                foreach (cur[i]) rx_bytes.push_back(cur[i]);
                rx_len.push_back(cur.size());
            end
        end
    end

    always @(posedge scl) begin
        if (in_frame) begin
            if (bit_cnt == 8) begin
                bit_cnt = 0;  // ack clock
            end else begin
                shift_in = {shift_in[6:0], sda};
                bit_cnt++;
            end
        end
    end

    // ack driven from the falling edge after bit 8 to the next one
    always @(negedge scl) begin
        if (in_frame && bit_cnt == 8) begin
            if (cur.size() == 0 && nack_next) ignore = 1'b1;
            if (!ignore) cur.push_back(shift_in);
            sda_pull = !ignore;
        end else begin
            sda_pull = 1'b0;
        end
    end

endmodule

// ==== bench/pong_link_asserts.sv ====
module pong_link_asserts #(
    parameter int stop_limit = 64  // cycles from stop accept to release
) (
    input logic                  clk,
    input logic                  reset,
    input pong_link_pkg::owner_t owner,
    input logic                  m_ready,
    input logic                  m_start,
    input logic                  m_stop,
    input logic                  m_en,
    input logic                  ball_start,
    input logic                  score_start
);

    int fail_count = 0;

    assert property (@(posedge clk) disable iff (reset) !m_ready |=> $stable(owner))
        else begin
            fail_count++;
            $error("owner changed while the byte master was busy");
        end

    // a start reaches the master only on the cycle after its own sender won the grant
    assert property (@(posedge clk) disable iff (reset)
        (m_start && m_en && m_ready) |->
            ($past(owner) == pong_link_pkg::owner_none) &&
            ((owner == pong_link_pkg::owner_ball && $past(ball_start)) ||
             (owner == pong_link_pkg::owner_score && $past(score_start))))
        else begin
            fail_count++;
            $error("a start from a sender without the grant reached the master");
        end

    assert property (@(posedge clk) disable iff (reset)
        (m_stop && m_en && m_ready) |-> ##[1:stop_limit] (owner == pong_link_pkg::owner_none))
        else begin
            fail_count++;
            $error("owner not released after an accepted stop");
        end

endmodule

// ==== bench/pong_link_tb.sv ====
module pong_link_tb;

    localparam int clk_div = 4;
    localparam int period = 40;
    localparam int num_ops = 40;
    localparam longint watchdog_limit = 2 * num_ops * 10 * 40 * clk_div * period;

    logic       clk, reset, send_trigger, collision, lose, score_update;
    logic [9:0] ball_y;
    logic [7:0] ball_vy;
    logic [1:0] gravity_step;
    logic [6:0] score;
    logic       frame_done, score_done, nack, scl, sda_low, sda_in;
    logic       target_pull, nack_next;

    logic [7:0] exp_bytes [$];  // expected frames from the reference model
    int         exp_len [$];
    int         bytes_seen = 0;
    int         frames_seen = 0;
    int         exp_scores = 0;
    int         nack_count = 0;
    int         score_done_count = 0;
    int         checks = 0;
    int         errors = 0;

    pong_link_top #(
        .clk_div (clk_div)
    ) i_dut (
        .clk          (clk),
        .reset        (reset),
        .send_trigger (send_trigger),
        .ball_y       (ball_y),
        .ball_vy      (ball_vy),
        .gravity_step (gravity_step),
        .collision    (collision),
        .lose         (lose),
        .score_update (score_update),
        .score        (score),
        .sda_in       (sda_in),
        .frame_done   (frame_done),
        .score_done   (score_done),
        .nack         (nack),
        .scl          (scl),
        .sda_low      (sda_low)
    );

    i2c_target_model i_target (
        .scl       (scl),
        .sda       (sda_in),
        .nack_next (nack_next),
        .sda_pull  (target_pull)
    );

    bind i2c_bus_arbiter pong_link_asserts i_asserts (
        .clk         (clk),
        .reset       (reset),
        .owner       (owner),
        .m_ready     (m_ready),
        .m_start     (m_start),
        .m_stop      (m_stop),
        .m_en        (m_en),
        .ball_start  (ball_start),
        .score_start (score_start)
    );

    assign sda_in = ~(sda_low | target_pull);  // either side pulls the open drain line low

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (nack) nack_count++;
        if (score_done) score_done_count++;
    end

    initial begin
        #(watchdog_limit);
        $display("timeout: run did not finish within %0d time units", watchdog_limit);
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, want);
        end
    endtask

    task automatic expect_ball(input bit recorded);
        if (recorded) begin
            exp_bytes.push_back(pong_link_pkg::link_addr);
            exp_bytes.push_back(pong_link_pkg::frame_ball);
            exp_bytes.push_back({ball_y[9:8], 6'b0});
            exp_bytes.push_back(ball_y[7:0]);
            exp_bytes.push_back(ball_vy);
            exp_bytes.push_back({6'b0, gravity_step});
            exp_bytes.push_back({7'b0, collision});
            exp_bytes.push_back({7'b0, lose});
            exp_len.push_back(2 + pong_link_pkg::ball_payload_len);
        end
    endtask

    task automatic expect_score(input bit recorded);
        if (recorded) begin
            exp_bytes.push_back(pong_link_pkg::link_addr);
            exp_bytes.push_back(pong_link_pkg::frame_score);
            exp_bytes.push_back({lose, score});  // lose in bit 7
            exp_len.push_back(2 + pong_link_pkg::score_payload_len);
        end
        exp_scores++;
    endtask

    task automatic randomize_ball();
        ball_y       = 10'($urandom);
        ball_vy      = 8'($urandom);
        gravity_step = 2'($urandom);
        collision    = 1'($urandom);
        lose         = 1'($urandom);
    endtask

    task automatic ball_send(input bit recorded);
        int stops_before;
        stops_before = i_target.stop_count;
        randomize_ball();
        send_trigger = 1'b1;
        expect_ball(recorded);
        next_cycle();
        while (!frame_done) next_cycle();
        if (i_target.stop_count == stops_before) begin
            errors++;
            $display("error at %0t: frame_done rose before the ball frame's stop", $time);
        end
        repeat ($urandom_range(0, 3)) begin
            next_cycle();
            check_eq("frame_done", frame_done, 1'b1);
        end
        send_trigger = 1'b0;
        next_cycle();
        check_eq("frame_done", frame_done, 1'b0);
    endtask

    task automatic score_send(input bit recorded);
        int done_before;
        done_before  = score_done_count;
        score        = 7'($urandom);
        lose         = 1'($urandom);
        score_update = 1'b1;
        expect_score(recorded);
        next_cycle();
        score_update = 1'b0;
        repeat (4) next_cycle();
        // lands mid-frame and must be dropped
        score        = 7'($urandom);
        lose         = ~lose;
        score_update = 1'b1;
        next_cycle();
        score_update = 1'b0;
        while (score_done_count == done_before) next_cycle();
    endtask

    task automatic both_send();
        int done_before;
        done_before = score_done_count;
        randomize_ball();
        score        = 7'($urandom);
        send_trigger = 1'b1;
        score_update = 1'b1;
        expect_ball(1'b1);  // ball wins the tie
        expect_score(1'b1);
        next_cycle();
        score_update = 1'b0;
        while (!frame_done) next_cycle();
        send_trigger = 1'b0;
        while (score_done_count == done_before) next_cycle();
    endtask

    task automatic compare_frames();
        check_eq("frame count", i_target.rx_len.size(), exp_len.size());
        check_eq("byte count", i_target.rx_bytes.size(), exp_bytes.size());
        for (int f = frames_seen; f < exp_len.size(); f++) begin
            if (f < i_target.rx_len.size()) begin
                check_eq($sformatf("rx_len[%0d]", f), i_target.rx_len[f], exp_len[f]);
            end
        end
        frames_seen = exp_len.size();
        for (int i = bytes_seen; i < exp_bytes.size(); i++) begin
            if (i < i_target.rx_bytes.size()) begin
                check_eq($sformatf("rx_bytes[%0d]", i), i_target.rx_bytes[i], exp_bytes[i]);
            end
        end
        bytes_seen = exp_bytes.size();
    endtask

    initial begin
        int op;
        int nacks_before;
        int stops_before;
        int frames;
        int assert_errors;
        void'($urandom(72468));
        reset        = 1'b1;
        send_trigger = 1'b0;
        score_update = 1'b0;
        nack_next    = 1'b0;
        ball_y       = '0;
        ball_vy      = '0;
        gravity_step = '0;
        collision    = 1'b0;
        lose         = 1'b0;
        score        = '0;
        repeat (2) @(posedge clk);
        #5;
        reset = 1'b0;
        check_eq("scl", scl, 1'b1);
        check_eq("sda_low", sda_low, 1'b0);
        for (int n = 0; n < num_ops; n++) begin
            op           = $urandom_range(0, 3);
            nacks_before = nack_count;
            stops_before = i_target.stop_count;
            frames       = (op == 2) ? 2 : 1;
            nack_next    = (op == 3);
            case (op)
                0: ball_send(1'b1);
                1: score_send(1'b1);
                2: both_send();
                default: begin
                    if ($urandom_range(0, 1) == 1) ball_send(1'b0);
                    else score_send(1'b0);
                end
            endcase
            nack_next = 1'b0;
            repeat (3) next_cycle();
            check_eq("stops", i_target.stop_count - stops_before, frames);
            if (op == 3 && nack_count == nacks_before) begin
                errors++;
                $display("error at %0t: no nack pulse during a nacked frame", $time);
            end else if (op != 3 && nack_count != nacks_before) begin
                errors++;
                $display("error at %0t: nack pulsed during an acked frame", $time);
            end
            check_eq("score_done pulses", score_done_count, exp_scores);
            compare_frames();
            check_eq("scl", scl, 1'b1);
            check_eq("sda_low", sda_low, 1'b0);
        end
        assert_errors = i_dut.i_arb.i_asserts.fail_count;
        $display("checks %0d, check errors %0d, assertion errors %0d",
                 checks, errors, assert_errors);
        if (errors == 0 && assert_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
src/pong_link_pkg.sv
src/i2c_byte_master.sv
src/i2c_bus_arbiter.sv
src/ball_frame_sender.sv
src/score_frame_sender.sv
src/pong_link_top.sv
bench/i2c_target_model.sv
bench/pong_link_asserts.sv
bench/pong_link_tb.sv
